/* hw/fl_pkg.sv */
package fl_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DATA_WIDTH = 16;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_BITS  = 2;
  localparam int NUM_ROWS   = 16;  // Rows per bank
  localparam int ROW_BITS   = 4;
  localparam int ADDR_BITS  = BANK_BITS + ROW_BITS;  // {bank, row}

  // Bank port opcode
  typedef enum logic [1:0] {
    BANK_IDLE  = 2'd0,
    BANK_READ  = 2'd1,
    BANK_WRITE = 2'd2
  } bank_op_e;

  typedef enum logic {
    FL_FILL = 1'b0,  // Loading row numbers after reset
    FL_RUN  = 1'b1
  } fl_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    bank_op_e              op;
    logic [ROW_BITS-1:0]   row;
    logic [DATA_WIDTH-1:0] data;
  } bank_cmd_t;

  // One read in flight
  typedef struct packed {
    logic                 vld;
    logic [BANK_BITS-1:0] bank;
    logic                 deq;  // Release the row after the read
  } rd_slot_t;

endpackage

/* hw/bank_free_list.sv */
`timescale 1ns/1ps

module bank_free_list
  import fl_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                pop,
  input  logic                push,
  input  logic [ROW_BITS-1:0] push_row,
  output logic [ROW_BITS-1:0] top_row,
  output logic                nonempty,
  output logic                ready
);

  fl_state_e           state;
  logic [ROW_BITS:0]   count;  // 0 to NUM_ROWS
  logic [ROW_BITS-1:0] wr_idx;
  logic [ROW_BITS-1:0] top_idx;
  logic                full;
  logic [ROW_BITS-1:0] stack [NUM_ROWS];

  assign wr_idx   = count[ROW_BITS-1:0];
  assign top_idx  = wr_idx - 1'b1;  // Wraps to last slot when full
  assign full     = count == (ROW_BITS+1)'(NUM_ROWS);
  assign top_row  = stack[top_idx];
  assign ready    = state == FL_RUN;
  assign nonempty = ready && (count != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State and depth
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FL_FILL;
      count <= '0;
    end else if (state == FL_FILL) begin
      count <= count + 1'b1;  // One row per cycle
      if (count == NUM_ROWS - 1) begin
        state <= FL_RUN;
      end
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end
  end

  // Stack storage
  always_ff @(posedge clk) begin
    if (state == FL_FILL) begin
      stack[wr_idx] <= wr_idx;
    end else if (push && pop) begin
      stack[top_idx] <= push_row;  // Replace the popped top
    end else if (push) begin
      stack[wr_idx] <= push_row;
    end
  end

  // Every row is either free or allocated
  a_push_not_full: assert property (@(posedge clk) disable iff (rst)
    push |-> !full);

endmodule

/* hw/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram
  import fl_pkg::*;
#(
  parameter int RD_LATENCY = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  bank_cmd_t             cmd,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [NUM_ROWS];
  logic [DATA_WIDTH-1:0] data_sr [RD_LATENCY];

  // Single port, one access per cycle
  always_ff @(posedge clk) begin
    if (cmd.op == BANK_WRITE) begin
      mem[cmd.row] <= cmd.data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read data pipe
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (cmd.op == BANK_READ) begin
      data_sr[0] <= mem[cmd.row];
    end
    for (int i = 1; i < RD_LATENCY; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

  assign rd_data = data_sr[RD_LATENCY-1];  // Last stage

  a_op_legal: assert property (@(posedge clk) disable iff (rst)
    cmd.op inside {BANK_IDLE, BANK_READ, BANK_WRITE});

endmodule

/* hw/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter
  import fl_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  input  logic [1:0]                         write,
  input  logic [DATA_WIDTH-1:0]              din0,
  input  logic [DATA_WIDTH-1:0]              din1,
  input  logic                               read,
  input  logic                               rd_deq,
  input  logic [ADDR_BITS-1:0]               rd_adr,
  input  logic [NUM_BANKS-1:0]               nonempty,
  input  logic [NUM_BANKS-1:0][ROW_BITS-1:0] top_row,
  output logic [NUM_BANKS-1:0]               pop,
  output bank_cmd_t [NUM_BANKS-1:0]          cmd,
  output rd_slot_t                           rd_slot,
  output logic [ADDR_BITS-1:0]               wr_adr0,
  output logic [ADDR_BITS-1:0]               wr_adr1,
  output logic                               wr_bp
);

  logic [BANK_BITS-1:0] rd_bank;
  logic [ROW_BITS-1:0]  rd_row;
  logic [BANK_BITS-1:0] first_bank;
  logic [BANK_BITS-1:0] second_bank;
  logic [BANK_BITS-1:0] w1_bank;
  logic [NUM_BANKS-1:0] eligible;
  logic [NUM_BANKS-1:0] grant_rd;
  logic [NUM_BANKS-1:0] grant_w0;
  logic [NUM_BANKS-1:0] grant_w1;
  logic [2:0]           n_elig;
  logic [2:0]           n_req;

  assign rd_bank  = rd_adr[ADDR_BITS-1:ROW_BITS];
  assign rd_row   = rd_adr[ROW_BITS-1:0];
  assign grant_rd = read ? (NUM_BANKS'(1) << rd_bank) : '0;  // Read always wins its bank
  assign eligible = nonempty & ~grant_rd;

  // Lowest two eligible banks
  always_comb begin
    logic [1:0] found;
    found       = '0;
    first_bank  = '0;
    second_bank = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (eligible[b]) begin
        if (found == 2'd0) first_bank = BANK_BITS'(b);
        else if (found == 2'd1) second_bank = BANK_BITS'(b);
        if (found != 2'd2) found = found + 2'd1;
      end
    end
  end

  assign n_elig = 3'($countones(eligible));
  assign n_req  = {2'b00, write[0]} + {2'b00, write[1]};
  assign wr_bp  = n_elig < n_req;

  assign w1_bank  = write[0] ? second_bank : first_bank;
  assign grant_w0 = (write[0] && !wr_bp) ? (NUM_BANKS'(1) << first_bank) : '0;
  assign grant_w1 = (write[1] && !wr_bp) ? (NUM_BANKS'(1) << w1_bank) : '0;

  assign wr_adr0 = {first_bank, top_row[first_bank]};
  assign wr_adr1 = {w1_bank, top_row[w1_bank]};
  assign pop     = grant_w0 | grant_w1;

  assign rd_slot = '{vld: read, bank: rd_bank, deq: read && rd_deq};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank commands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      cmd[b].op   = BANK_IDLE;
      cmd[b].row  = '0;
      cmd[b].data = '0;
      if (grant_rd[b]) begin
        cmd[b].op  = BANK_READ;
        cmd[b].row = rd_row;
      end else if (grant_w0[b]) begin
        cmd[b].op   = BANK_WRITE;
        cmd[b].row  = top_row[b];  // Row popped at the edge
        cmd[b].data = din0;
      end else if (grant_w1[b]) begin
        cmd[b].op   = BANK_WRITE;
        cmd[b].row  = top_row[b];
        cmd[b].data = din1;
      end
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    ((grant_rd & grant_w0) | (grant_rd & grant_w1) | (grant_w0 & grant_w1)) == '0);

  // Free list must hold a row before it is handed out
  a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
    (pop & ~nonempty) == '0);

endmodule

/* hw/read_pipe.sv */
`timescale 1ns/1ps

module read_pipe
  import fl_pkg::*;
#(
  parameter int RD_LATENCY = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  rd_slot_t                             slot_in,
  input  logic [ROW_BITS-1:0]                  slot_row,
  input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] rd_data,
  output logic [NUM_BANKS-1:0]                 push,
  output logic [ROW_BITS-1:0]                  push_row,
  output logic                                 rd_vld,
  output logic [DATA_WIDTH-1:0]                rd_dout
);

  rd_slot_t            slot_sr [RD_LATENCY];
  rd_slot_t            slot_out;
  logic [ROW_BITS-1:0] row_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reads in flight
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RD_LATENCY; i++) begin
        slot_sr[i] <= '0;
      end
    end else begin
      slot_sr[0] <= slot_in;
      for (int i = 1; i < RD_LATENCY; i++) begin
        slot_sr[i] <= slot_sr[i-1];
      end
    end
  end

  // Row is only needed for the release at stage one
  always_ff @(posedge clk) begin
    row_q <= slot_row;
  end

  // Dequeue one cycle after the read
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      push[b] = slot_sr[0].vld && slot_sr[0].deq && (slot_sr[0].bank == BANK_BITS'(b));
    end
  end

  assign push_row = row_q;

  // Result stage
  assign slot_out = slot_sr[RD_LATENCY-1];
  assign rd_vld   = slot_out.vld;
  assign rd_dout  = rd_data[slot_out.bank];

endmodule

/* hw/fl_buf_top.sv */
`timescale 1ns/1ps

module fl_buf_top
  import fl_pkg::*;
#(
  parameter int RD_LATENCY = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  ready,
  input  logic [1:0]            write,
  input  logic [DATA_WIDTH-1:0] din0,
  input  logic [DATA_WIDTH-1:0] din1,
  output logic [ADDR_BITS-1:0]  wr_adr0,
  output logic [ADDR_BITS-1:0]  wr_adr1,
  output logic                  wr_bp,
  input  logic                  read,
  input  logic                  rd_deq,
  input  logic [ADDR_BITS-1:0]  rd_adr,
  output logic                  rd_vld,
  output logic [DATA_WIDTH-1:0] rd_dout
);

  logic [1:0]                               write_en;
  logic                                     read_en;
  logic [NUM_BANKS-1:0]                     nonempty;
  logic [NUM_BANKS-1:0]                     pop;
  logic [NUM_BANKS-1:0]                     push;
  logic [NUM_BANKS-1:0]                     fl_ready;
  logic [NUM_BANKS-1:0][ROW_BITS-1:0]       top_row;
  logic [ROW_BITS-1:0]                      push_row;
  bank_cmd_t [NUM_BANKS-1:0]                cmd;
  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]     rd_data;
  rd_slot_t                                 rd_slot;

  assign ready    = &fl_ready;
  assign write_en = write & {2{ready}};  // No traffic while the stacks fill
  assign read_en  = read & ready;

  bank_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .write    (write_en),
    .din0     (din0),
    .din1     (din1),
    .read     (read_en),
    .rd_deq   (rd_deq),
    .rd_adr   (rd_adr),
    .nonempty (nonempty),
    .top_row  (top_row),
    .pop      (pop),
    .cmd      (cmd),
    .rd_slot  (rd_slot),
    .wr_adr0  (wr_adr0),
    .wr_adr1  (wr_adr1),
    .wr_bp    (wr_bp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-bank free list and data array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_free_list u_fl (
      .clk      (clk),
      .rst      (rst),
      .pop      (pop[b]),
      .push     (push[b]),
      .push_row (push_row),
      .top_row  (top_row[b]),
      .nonempty (nonempty[b]),
      .ready    (fl_ready[b])
    );

    bank_ram #(
      .RD_LATENCY (RD_LATENCY)
    ) u_ram (
      .clk     (clk),
      .rst     (rst),
      .cmd     (cmd[b]),
      .rd_data (rd_data[b])
    );
  end

  read_pipe #(
    .RD_LATENCY (RD_LATENCY)
  ) u_rpipe (
    .clk      (clk),
    .rst      (rst),
    .slot_in  (rd_slot),
    .slot_row (rd_adr[ROW_BITS-1:0]),
    .rd_data  (rd_data),
    .push     (push),
    .push_row (push_row),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout)
  );

endmodule

/* test/fl_buf_tb.sv */
`timescale 1ns/1ps

module fl_buf_tb
  import fl_pkg::*;
();

  localparam int RD_LATENCY     = 2;
  localparam int NUM_ADDR       = NUM_BANKS * NUM_ROWS;
  localparam int FILL_LIMIT     = 150;
  localparam int RANDOM_CYCLES  = 1500;
  localparam int TIMEOUT_CYCLES = 2000;  // Reset, fill and random traffic plus margin

  logic                  clk;
  logic                  rst;
  logic                  ready;
  logic [1:0]            write;
  logic [DATA_WIDTH-1:0] din0;
  logic [DATA_WIDTH-1:0] din1;
  logic [ADDR_BITS-1:0]  wr_adr0;
  logic [ADDR_BITS-1:0]  wr_adr1;
  logic                  wr_bp;
  logic                  read;
  logic                  rd_deq;
  logic [ADDR_BITS-1:0]  rd_adr;
  logic                  rd_vld;
  logic [DATA_WIDTH-1:0] rd_dout;

  // Reference model state
  logic                  alloc [NUM_ADDR];
  logic [DATA_WIDTH-1:0] ref_mem [NUM_ADDR];
  int                    free_cnt [NUM_BANKS];
  int                    n_alloc;
  logic                  rel_vld;  // Release seen last cycle
  logic [BANK_BITS-1:0]  rel_bank;
  logic [RD_LATENCY-1:0] vld_pipe;
  logic [DATA_WIDTH-1:0] data_pipe [RD_LATENCY];
  int                    run_cycles;  // Compare cycles since reset release
  int                    cycle_cnt;

  fl_buf_top #(
    .RD_LATENCY (RD_LATENCY)
  ) dut (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .write   (write),
    .din0    (din0),
    .din1    (din1),
    .wr_adr0 (wr_adr0),
    .wr_adr1 (wr_adr1),
    .wr_bp   (wr_bp),
    .read    (read),
    .rd_deq  (rd_deq),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_problem(input string msg);
    $display("[ERROR] %s", msg);
    stop_with_failure();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected back-pressure and bank per write port from free counts
  function automatic void ref_grant(
    input  logic                 rdy,
    input  logic [1:0]           wr,
    input  logic                 rd,
    input  logic [ADDR_BITS-1:0] ra,
    output logic                 bp,
    output logic [BANK_BITS-1:0] bank0,
    output logic [BANK_BITS-1:0] bank1
  );
    int elig [NUM_BANKS];
    int n_elig;
    int n_req;
    n_elig = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (free_cnt[b] > 0 && !(rd && rdy && ra[ADDR_BITS-1:ROW_BITS] == b)) begin
        elig[n_elig] = b;
        n_elig++;
      end
    end
    n_req = rdy ? (int'(wr[0]) + int'(wr[1])) : 0;
    bp    = n_elig < n_req;
    bank0 = (n_elig > 0) ? BANK_BITS'(elig[0]) : '0;
    if (!wr[0]) bank1 = bank0;  // Port 1 alone takes the lowest bank
    else bank1 = (n_elig > 1) ? BANK_BITS'(elig[1]) : '0;
  endfunction

  // First allocated address at or after a random start
  function automatic logic [ADDR_BITS-1:0] pick_allocated();
    int                   start;
    logic [ADDR_BITS-1:0] a;
    start = $urandom_range(0, NUM_ADDR - 1);
    pick_allocated = '0;
    for (int i = NUM_ADDR - 1; i >= 0; i--) begin
      a = ADDR_BITS'((start + i) % NUM_ADDR);
      if (alloc[a]) pick_allocated = a;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Comparing process at the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin : compare
    logic                 exp_ready;
    logic                 exp_bp;
    logic [BANK_BITS-1:0] exp_b0;
    logic [BANK_BITS-1:0] exp_b1;
    logic [BANK_BITS-1:0] rd_bank;
    logic                 rd_acc;
    logic [1:0]           wr_acc;
    if (!rst) begin
      run_cycles++;
      exp_ready = run_cycles > NUM_ROWS;  // Stacks fill one row per cycle
      assert (ready === exp_ready) else report_mismatch("ready", ready, exp_ready);
      ref_grant(exp_ready, write, read, rd_adr, exp_bp, exp_b0, exp_b1);
      rd_acc  = read && exp_ready;
      wr_acc  = (exp_ready && !exp_bp) ? write : 2'b00;
      rd_bank = rd_adr[ADDR_BITS-1:ROW_BITS];
      assert (wr_bp === exp_bp) else report_mismatch("wr_bp", wr_bp, exp_bp);
      assert (rd_vld === vld_pipe[RD_LATENCY-1])
        else report_mismatch("rd_vld", rd_vld, vld_pipe[RD_LATENCY-1]);
      if (vld_pipe[RD_LATENCY-1]) begin
        assert (rd_dout === data_pipe[RD_LATENCY-1])
          else report_mismatch("rd_dout", rd_dout, data_pipe[RD_LATENCY-1]);
      end
      if (wr_acc[0]) begin
        assert (wr_adr0[ADDR_BITS-1:ROW_BITS] === exp_b0)
          else report_mismatch("wr_adr0 bank", wr_adr0[ADDR_BITS-1:ROW_BITS], exp_b0);
        assert (!alloc[wr_adr0])
          else report_problem($sformatf("wr_adr0 0x%0h handed out while allocated", wr_adr0));
      end
      if (wr_acc[1]) begin
        assert (wr_adr1[ADDR_BITS-1:ROW_BITS] === exp_b1)
          else report_mismatch("wr_adr1 bank", wr_adr1[ADDR_BITS-1:ROW_BITS], exp_b1);
        assert (!alloc[wr_adr1])
          else report_problem($sformatf("wr_adr1 0x%0h handed out while allocated", wr_adr1));
      end
      if (wr_acc == 2'b11) begin
        assert (wr_adr0[ADDR_BITS-1:ROW_BITS] != wr_adr1[ADDR_BITS-1:ROW_BITS])
          else report_problem("both writes were given the same bank");
      end
      if (rd_acc) begin
        assert (!(wr_acc[0] && wr_adr0[ADDR_BITS-1:ROW_BITS] == rd_bank) &&
                !(wr_acc[1] && wr_adr1[ADDR_BITS-1:ROW_BITS] == rd_bank))
          else report_problem("a write landed in the bank of the same-cycle read");
      end

      // Row released last cycle is back on its stack now
      if (rel_vld) free_cnt[rel_bank]++;
      rel_vld  = rd_acc && rd_deq;
      rel_bank = rd_bank;
      vld_pipe = {vld_pipe[RD_LATENCY-2:0], rd_acc};
      for (int i = RD_LATENCY - 1; i > 0; i--) begin
        data_pipe[i] = data_pipe[i-1];
      end
      data_pipe[0] = ref_mem[rd_adr];
      if (rd_acc && rd_deq) begin
        alloc[rd_adr] = 1'b0;
        n_alloc--;
      end
      if (wr_acc[0]) begin
        alloc[wr_adr0]   = 1'b1;
        ref_mem[wr_adr0] = din0;
        free_cnt[exp_b0]--;
        n_alloc++;
      end
      if (wr_acc[1]) begin
        alloc[wr_adr1]   = 1'b1;
        ref_mem[wr_adr1] = din1;
        free_cnt[exp_b1]--;
        n_alloc++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_traffic(input logic [1:0] wr, input int rd_pct, input int deq_pct);
    write  = wr;
    din0   = DATA_WIDTH'($urandom);
    din1   = DATA_WIDTH'($urandom);
    read   = (n_alloc > 0) && ($urandom_range(0, 99) < rd_pct);
    rd_adr = pick_allocated();
    rd_deq = read && ($urandom_range(0, 99) < deq_pct);
    step();
  endtask

  initial begin
    int fill_cycles;
    void'($urandom(64));
    rst         = 1'b1;
    write       = '0;
    din0        = '0;
    din1        = '0;
    read        = 1'b0;
    rd_deq      = 1'b0;
    rd_adr      = '0;
    cycle_cnt   = 0;
    run_cycles  = 0;
    n_alloc     = 0;
    rel_vld     = 1'b0;
    rel_bank    = '0;
    vld_pipe    = '0;
    for (int a = 0; a < NUM_ADDR; a++) begin
      alloc[a] = 1'b0;
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      free_cnt[b] = NUM_ROWS;
    end
    repeat (10) @(posedge clk);
    #2;
    rst   = 1'b0;
    write = 2'b11;  // Must be ignored while the stacks fill
    while (!ready) begin
      step();
    end

    // Fill every row with reads but no release
    fill_cycles = 0;
    while (n_alloc < NUM_ADDR && fill_cycles < FILL_LIMIT) begin
      drive_traffic(2'($urandom_range(1, 3)), 50, 0);
      fill_cycles++;
    end
    assert (n_alloc == NUM_ADDR)
      else report_problem("buffer never reached full allocation");
    repeat (4) begin
      drive_traffic(2'b11, 0, 0);
    end

    // Mixed traffic with release rate following occupancy
    repeat (RANDOM_CYCLES) begin
      drive_traffic(2'($urandom), 75, (n_alloc > 40) ? 70 : 25);
    end
    repeat (RD_LATENCY + 2) begin
      drive_traffic(2'b00, 0, 0);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* sim.f */
hw/fl_pkg.sv
hw/bank_free_list.sv
hw/bank_ram.sv
hw/bank_arbiter.sv
hw/read_pipe.sv
hw/fl_buf_top.sv
test/fl_buf_tb.sv
